/* include/knight_cmd_consts.svh */
`ifndef KNIGHT_CMD_CONSTS_SVH
`define KNIGHT_CMD_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////
`define KC_HEAD_W 12  // Gyro heading and PID error width.
`define KC_FRWRD_W 10  // Forward speed register width.
`define KC_SQ_W 4  // Square count field width.

////////////////////////////////////////////////////////////////////////////
// Forward speed ramp steps, applied once per heading_rdy
////////////////////////////////////////////////////////////////////////////
`define KC_INC_FAST 10'h020  // Ramp up step, fast simulation.
`define KC_INC_SLOW 10'h003  // Ramp up step, real robot.
`define KC_DEC_FAST 10'h040  // Ramp down step, fast simulation.
`define KC_DEC_SLOW 10'h006  // Ramp down step, real robot.

////////////////////////////////////////////////////////////////////////////
// IR nudge terms added into the heading error
////////////////////////////////////////////////////////////////////////////
`define KC_NUDGE_POS_FAST 12'h1FF  // Left IR hit, fast simulation.
`define KC_NUDGE_NEG_FAST 12'hE00  // Right IR hit, fast simulation.
`define KC_NUDGE_POS_SLOW 12'h05F  // Left IR hit, real robot.
`define KC_NUDGE_NEG_SLOW 12'hFA1  // Right IR hit, real robot.

// Motion may start once |error| drops below this.
`define KC_ALIGN_THRESH 12'h02C

`endif

/* hw/knight_cmd_pkg.sv */
`default_nettype none

`include "knight_cmd_consts.svh"

package knight_cmd_pkg;

  // Opcodes in cmd[15:12].
  typedef enum logic [3:0] {
    CAL     = 4'h2,  // Gyro calibration.
    MOV     = 4'h4,  // Plain move.
    FANFARE = 4'h5,  // Move with the charge tune.
    TOUR    = 4'h6   // Hand off to the tour logic.
  } op_t;

  // Command processor FSM states.
  typedef enum logic [2:0] {
    IDLE,       // Waiting for cmd_rdy.
    CALIBRATE,  // Waiting for cal_done.
    MOVE,       // Turning toward the desired heading.
    INCR,       // Ramping up and counting squares.
    DECR        // Ramping down to a stop.
  } state_t;

  // Bluetooth command word.
  typedef struct packed {
    op_t                  op;       // Opcode.
    logic [7:0]           head;     // Heading field, upper bits of desired heading.
    logic [`KC_SQ_W-1:0]  squares;  // Squares to travel.
  } cmd_t;

  // IR sensor group.
  typedef struct packed {
    logic lft;   // Left line sensor.
    logic cntr;  // Centre line sensor, pulses per line crossed.
    logic rght;  // Right line sensor.
  } ir_t;

  // Forward speed ramp control from the FSM.
  typedef struct packed {
    logic clr;  // Zero the speed at once.
    logic inc;  // Ramp up on heading_rdy.
    logic dec;  // Ramp down on heading_rdy.
  } speed_ctrl_t;

endpackage

`default_nettype wire

/* hw/heading_err.sv */
`default_nettype none
`timescale 1ns/100ps

`include "knight_cmd_consts.svh"

module heading_err #(
  parameter bit fast_sim = 1  // Larger nudge for short simulations.
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  knight_cmd_pkg::cmd_t         cmd,       // Command, sampled on cmd_load.
  input  logic                         cmd_load,  // Command accepted strobe.
  input  logic signed [`KC_HEAD_W-1:0] heading,   // Gyro heading.
  input  knight_cmd_pkg::ir_t          ir,        // Side IR sensors.
  output logic signed [`KC_HEAD_W-1:0] error,     // Error to the PID.
  output logic                         aligned    // Close enough to start moving.
);

  // Nudge terms for the chosen mode.
  localparam logic [`KC_HEAD_W-1:0] nudge_pos =
    fast_sim ? `KC_NUDGE_POS_FAST : `KC_NUDGE_POS_SLOW;
  localparam logic [`KC_HEAD_W-1:0] nudge_neg =
    fast_sim ? `KC_NUDGE_NEG_FAST : `KC_NUDGE_NEG_SLOW;

  logic signed [`KC_HEAD_W-1:0] desired_heading;  // Target heading of the current move.
  logic signed [`KC_HEAD_W-1:0] nudge;            // IR correction term.
  logic        [`KC_HEAD_W-1:0] error_abs;        // Magnitude of error.

  ////////////////////////////////////////////////////////////////////////////
  // Desired heading
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      desired_heading <= '0;  // Face north out of reset.
    end else if (cmd_load) begin
      if (cmd.head == 8'h00) begin
        desired_heading <= '0;  // North is exactly zero.
      end else begin
        desired_heading <= {cmd.head, 4'hF};  // Pad into the middle of the step.
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Error and alignment
  ////////////////////////////////////////////////////////////////////////////
  // Left sensor wins if both see the line.
  always_comb begin
    if (ir.lft) begin
      nudge = nudge_pos;  // Drifted left, steer right.
    end else if (ir.rght) begin
      nudge = nudge_neg;  // Drifted right, steer left.
    end else begin
      nudge = '0;
    end
  end

  assign error = heading - desired_heading + nudge;  // Wraps modulo 4096.

  assign error_abs = error[`KC_HEAD_W-1] ? -error : error;  // Two's complement magnitude.

  assign aligned = (error_abs < `KC_ALIGN_THRESH);  // Heading is close enough.

endmodule

`default_nettype wire

/* hw/move_progress.sv */
`default_nettype none
`timescale 1ns/100ps

`include "knight_cmd_consts.svh"

module move_progress #(
  parameter bit fast_sim = 1  // Coarse ramp steps for short simulations.
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  knight_cmd_pkg::cmd_t          cmd,          // Command, sampled on cmd_load.
  input  logic                          cmd_load,     // Command accepted strobe.
  input  knight_cmd_pkg::speed_ctrl_t   speed,        // Ramp control from the FSM.
  input  logic                          heading_rdy,  // New gyro sample, paces the ramp.
  input  logic                          cntr_ir,      // Centre IR line sensor.
  output logic [`KC_FRWRD_W-1:0]        frwrd,        // Forward speed.
  output logic                          zero,         // Speed is zero.
  output logic                          move_done     // All squares counted.
);

  localparam logic [`KC_FRWRD_W-1:0] inc_step =
    fast_sim ? `KC_INC_FAST : `KC_INC_SLOW;
  localparam logic [`KC_FRWRD_W-1:0] dec_step =
    fast_sim ? `KC_DEC_FAST : `KC_DEC_SLOW;

  logic                 max_spd;      // Top two speed bits set.
  logic                 cntr_prev;    // Centre IR, one cycle late.
  logic                 cntr_rise;    // Line crossing started.
  logic [`KC_SQ_W:0]    pulse_cnt;    // Line edges since the command, two per square.
  logic [`KC_SQ_W-1:0]  square_cnt;   // Squares asked for.

  ////////////////////////////////////////////////////////////////////////////
  // Forward speed ramp
  ////////////////////////////////////////////////////////////////////////////
  assign zero    = (frwrd == '0);
  assign max_spd = &frwrd[`KC_FRWRD_W-1 -: 2];  // Saturation level.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frwrd <= '0;
    end else if (speed.clr) begin
      frwrd <= '0;  // Start each move from standstill.
    end else if (heading_rdy) begin
      if (speed.inc && !max_spd) begin
        frwrd <= frwrd + inc_step;  // Ramp up.
      end else if (speed.dec && !zero) begin
        frwrd <= frwrd - dec_step;  // Ramp down.
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Square counting
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cntr_prev <= 1'b0;
    end else begin
      cntr_prev <= cntr_ir;  // Edge detect history.
    end
  end

  assign cntr_rise = cntr_ir & ~cntr_prev;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pulse_cnt <= '0;
    end else if (cmd_load) begin
      pulse_cnt <= '0;  // Fresh count per command.
    end else if (cntr_rise) begin
      pulse_cnt <= pulse_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_load) begin
      square_cnt <= cmd.squares;  // Held for the whole move.
    end
  end

  // Each square has two line edges under the centre sensor.
  assign move_done = (pulse_cnt == {square_cnt, 1'b0});

endmodule

`default_nettype wire

/* hw/cmd_sequencer.sv */
`default_nettype none
`timescale 1ns/100ps

module cmd_sequencer (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cmd_rdy,      // Command waiting.
  input  knight_cmd_pkg::op_t          op,           // Opcode of the waiting command.
  input  logic                         cal_done,     // Gyro calibration finished.
  input  logic                         aligned,      // Heading error is small.
  input  logic                         move_done,    // All squares counted.
  input  logic                         zero,         // Forward speed is zero.
  output logic                         clr_cmd_rdy,  // Command consumed.
  output logic                         cmd_load,     // Capture the command.
  output logic                         strt_cal,     // Kick off gyro calibration.
  output logic                         send_resp,    // Command finished.
  output logic                         tour_go,      // Start the tour logic.
  output logic                         fanfare_go,   // Play the charge tune.
  output logic                         moving,       // Robot is driving.
  output knight_cmd_pkg::speed_ctrl_t  speed         // Ramp control.
);

  import knight_cmd_pkg::*;

  state_t state;      // Current state.
  state_t nxt_state;  // Next state.
  op_t    op_q;       // Opcode of the command in progress.

  ////////////////////////////////////////////////////////////////////////////
  // State and opcode registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  // The command word may change once clr_cmd_rdy is seen.
  always_ff @(posedge clk) begin
    if (cmd_load) begin
      op_q <= op;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state   = state;  // Hold by default.
    clr_cmd_rdy = 1'b0;
    cmd_load    = 1'b0;
    strt_cal    = 1'b0;
    send_resp   = 1'b0;
    tour_go     = 1'b0;
    fanfare_go  = 1'b0;
    moving      = 1'b0;
    speed       = '0;

    unique case (state)
      IDLE: begin
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;  // Every opcode is consumed.
          cmd_load    = 1'b1;  // Heading and squares load now.
          case (op)
            TOUR: begin
              tour_go = 1'b1;  // Tour logic takes over, no response.
            end
            CAL: begin
              strt_cal  = 1'b1;
              nxt_state = CALIBRATE;
            end
            MOV, FANFARE: begin
              nxt_state = MOVE;  // Turn first.
            end
            default: begin
              nxt_state = IDLE;  // Unknown opcode is dropped.
            end
          endcase
        end
      end

      CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;  // Gyro ready.
          nxt_state = IDLE;
        end
      end

      MOVE: begin
        if (aligned) begin
          speed.clr = 1'b1;  // Ramp from zero.
          moving    = 1'b1;
          nxt_state = INCR;
        end
      end

      INCR: begin
        speed.inc = 1'b1;
        moving    = 1'b1;
        if (move_done) begin
          fanfare_go = (op_q == FANFARE);  // Tune starts as braking begins.
          nxt_state  = DECR;
        end
      end

      DECR: begin
        speed.dec = 1'b1;
        if (zero) begin
          send_resp = 1'b1;  // Stopped on the target square.
          nxt_state = IDLE;
        end else begin
          moving = 1'b1;  // Still rolling.
        end
      end

      default: begin
        nxt_state = IDLE;  // Recover from an unused encoding.
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/cmd_proc.sv */
`default_nettype none
`timescale 1ns/100ps

`include "knight_cmd_consts.svh"

module cmd_proc #(
  parameter bit fast_sim = 1  // Coarse steps for short simulations.
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  knight_cmd_pkg::cmd_t          cmd,          // Command from Bluetooth.
  input  logic                          cmd_rdy,      // Command waiting.
  input  logic                          cal_done,     // Gyro calibration finished.
  input  logic signed [`KC_HEAD_W-1:0]  heading,      // Gyro heading.
  input  logic                          heading_rdy,  // New gyro sample.
  input  knight_cmd_pkg::ir_t           ir,           // IR sensors.
  output logic                          clr_cmd_rdy,  // Command consumed.
  output logic                          send_resp,    // Command finished.
  output logic                          strt_cal,     // Start gyro calibration.
  output logic                          tour_go,      // Start the tour.
  output logic                          fanfare_go,   // Play the charge tune.
  output logic                          moving,       // Robot is driving.
  output logic signed [`KC_HEAD_W-1:0]  error,        // Error to the PID.
  output logic [`KC_FRWRD_W-1:0]        frwrd         // Forward speed.
);

  import knight_cmd_pkg::*;

  logic        cmd_load;   // Command accepted.
  logic        aligned;    // Heading close enough.
  logic        move_done;  // Squares all counted.
  logic        zero;       // Speed at zero.
  speed_ctrl_t speed;      // Ramp control.

  heading_err #(
    .fast_sim (fast_sim)
  ) heading_err_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .cmd_load (cmd_load),
    .heading  (heading),
    .ir       (ir),
    .error    (error),
    .aligned  (aligned)
  );

  move_progress #(
    .fast_sim (fast_sim)
  ) move_progress_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_load    (cmd_load),
    .speed       (speed),
    .heading_rdy (heading_rdy),
    .cntr_ir     (ir.cntr),
    .frwrd       (frwrd),
    .zero        (zero),
    .move_done   (move_done)
  );

  cmd_sequencer cmd_sequencer_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_rdy     (cmd_rdy),
    .op          (cmd.op),
    .cal_done    (cal_done),
    .aligned     (aligned),
    .move_done   (move_done),
    .zero        (zero),
    .clr_cmd_rdy (clr_cmd_rdy),
    .cmd_load    (cmd_load),
    .strt_cal    (strt_cal),
    .send_resp   (send_resp),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .moving      (moving),
    .speed       (speed)
  );

endmodule

`default_nettype wire

/* dv/cmd_proc_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module cmd_proc_tb;

  import knight_cmd_pkg::*;

  localparam string      stim_file = "dv/cmd_proc_stimulus.txt";
  localparam logic [9:0]  inc_step  = 10'h020;  // Fast ramp up step.
  localparam logic [9:0]  dec_step  = 10'h040;  // Fast ramp down step.
  localparam logic [9:0]  full_spd  = 10'h300;  // Top two bits set.

  // One line of the stimulus file.
  typedef struct packed {
    logic [15:0] cmd_word;   // Command word.
    logic [11:0] hdg;        // Gyro heading while turning.
    logic        lft;        // Left IR level.
    logic        rght;       // Right IR level.
    logic [11:0] exp_err;    // Expected error after acceptance.
    logic [7:0]  exp_steps;  // Expected ramp steps to full speed.
  } stim_t;

  logic               clk;
  logic               rst_n;
  cmd_t               cmd;
  logic               cmd_rdy;
  logic               cal_done;
  logic signed [11:0] heading;
  logic               heading_rdy;
  ir_t                ir;
  logic               clr_cmd_rdy, send_resp, strt_cal, tour_go, fanfare_go, moving;
  logic signed [11:0] error;
  logic [9:0]         frwrd;

  stim_t      recs[$];          // Loaded records.
  integer     seed;             // Centre IR gap generator.
  int         err_cnt = 0;
  int         check_cnt = 0;
  int         resp_cnt = 0;     // send_resp pulses seen.
  int         fan_cnt = 0;      // fanfare_go pulses seen.
  int         tour_cnt = 0;     // tour_go pulses seen.
  logic [9:0] fan_frwrd = '0;   // Speed when fanfare_go fired.
  int         cycle_cnt = 0;
  int         cycle_limit = 0;  // Zero until the records are known.
  logic [1:0] hr_phase = '0;
  bit         load_ok;

  cmd_proc #(
    .fast_sim (1'b1)
  ) cmd_proc_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_rdy     (cmd_rdy),
    .cal_done    (cal_done),
    .heading     (heading),
    .heading_rdy (heading_rdy),
    .ir          (ir),
    .clr_cmd_rdy (clr_cmd_rdy),
    .send_resp   (send_resp),
    .strt_cal    (strt_cal),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .moving      (moving),
    .error       (error),
    .frwrd       (frwrd)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clock, gyro pacing, pulse monitor and cycle limit
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period.
  end

  initial begin
    forever begin
      @(negedge clk);
      hr_phase = hr_phase + 1'b1;
      heading_rdy = (hr_phase == 2'd3);  // One cycle in four.
    end
  end

  // Pulses counted just before the edge that ends their cycle.
  always @(posedge clk) begin
    if (rst_n) begin
      if (send_resp) resp_cnt++;
      if (tour_go) tour_cnt++;
      if (fanfare_go) begin
        fan_cnt++;
        fan_frwrd = frwrd;
      end
    end
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_limit > 0);
    wait (cycle_cnt >= cycle_limit);
    $display("Run stopped after reaching the limit of %0d cycles", cycle_limit);
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_val(input string name, input logic [15:0] actual,
                           input logic [15:0] expected);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic report_stall(input string what);
    err_cnt++;
    $display("Gave up waiting for %s at %0t", what, $time);
  endtask

  task automatic tick();
    @(negedge clk);
    #1;  // Outputs settled for this cycle.
  endtask

  function automatic logic [11:0] des_heading(input logic [7:0] head);
    return (head == 8'h00) ? 12'h000 : {head, 4'hF};  // North is exact.
  endfunction

  task automatic load_stimulus(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [15:0] c;
    logic [11:0] h, e;
    logic        l, rt;
    logic [7:0]  s;
    stim_t       rec;
    ok = 1'b0;
    fd = $fopen(stim_file, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h", c, h, l, rt, e, s);
          if (n == 6) begin
            rec = '{cmd_word: c, hdg: h, lft: l, rght: rt, exp_err: e, exp_steps: s};
            recs.push_back(rec);
          end
        end
      end
      $fclose(fd);
      ok = (recs.size() > 0);
    end
  endtask

  // Presents a command and samples the acceptance cycle.
  task automatic offer_cmd(input stim_t r);
    @(negedge clk);
    cmd = cmd_t'(r.cmd_word);
    cmd_rdy = 1'b1;
    heading = r.hdg;
    ir.lft = r.lft;
    ir.rght = r.rght;
    #1;
    check_val("clr_cmd_rdy", clr_cmd_rdy, 1'b1);
  endtask

  task automatic drop_cmd_rdy();
    @(negedge clk);
    cmd_rdy = 1'b0;
    #1;
  endtask

  task automatic toggle_cntr(input int n);
    int gap;
    for (int i = 0; i < n; i++) begin
      gap = 2 + ($unsigned($random(seed)) % 4);  // 2 to 5 cycles.
      repeat (gap) @(negedge clk);
      ir.cntr = ~ir.cntr;
    end
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Per opcode sequences
  ////////////////////////////////////////////////////////////////////////////
  task automatic run_tour(input stim_t r);
    int resp_before;
    int tour_before;
    resp_before = resp_cnt;
    tour_before = tour_cnt;
    offer_cmd(r);
    check_val("tour_go", tour_go, 1'b1);
    check_val("strt_cal", strt_cal, 1'b0);
    drop_cmd_rdy();
    repeat (10) tick();
    check_val("send_resp count", resp_cnt - resp_before, 0);  // Tour never answers.
    check_val("tour_go count", tour_cnt - tour_before, 1);
  endtask

  task automatic run_cal(input stim_t r);
    int resp_before;
    resp_before = resp_cnt;
    offer_cmd(r);
    check_val("strt_cal", strt_cal, 1'b1);
    drop_cmd_rdy();
    repeat (6) begin
      tick();
      check_val("send_resp", send_resp, 1'b0);
    end
    @(negedge clk);
    cal_done = 1'b1;
    #1;
    check_val("send_resp", send_resp, 1'b1);
    @(negedge clk);
    cal_done = 1'b0;
    repeat (4) tick();
    check_val("send_resp count", resp_cnt - resp_before, 1);
  endtask

  task automatic run_move(input stim_t r);
    logic [9:0]  prev;
    logic [11:0] target;
    int          steps;
    int          waited;
    int          resp_before;
    int          fan_before;
    bit          is_fan;
    resp_before = resp_cnt;
    fan_before = fan_cnt;
    is_fan = (op_t'(r.cmd_word[15:12]) == FANFARE);
    target = des_heading(r.cmd_word[11:4]);
    offer_cmd(r);
    check_val("tour_go", tour_go, 1'b0);
    check_val("strt_cal", strt_cal, 1'b0);
    drop_cmd_rdy();
    check_val("error", $unsigned(error), r.exp_err);
    check_val("moving", moving, 1'b0);  // Still turning.
    @(negedge clk);
    heading = target;  // Turn complete.
    ir.lft = 1'b0;
    ir.rght = 1'b0;
    #1;
    check_val("error", $unsigned(error), 12'h000);
    check_val("moving", moving, 1'b1);
    prev = '0;
    steps = 0;
    waited = 0;
    while (frwrd != full_spd && waited < 200) begin
      tick();
      waited++;
      check_val("moving", moving, 1'b1);
      if (frwrd != prev) begin
        check_val("frwrd", frwrd, prev + inc_step);
        prev = frwrd;
        steps++;
      end
    end
    if (frwrd != full_spd) report_stall("frwrd to reach full speed");
    check_val("ramp steps", steps, r.exp_steps);
    repeat (8) tick();
    check_val("frwrd", frwrd, full_spd);  // Saturated.
    check_val("fanfare_go count", fan_cnt - fan_before, 0);
    toggle_cntr(4 * r.cmd_word[3:0]);  // Two rising edges per square.
    prev = frwrd;
    waited = 0;
    while (!send_resp && waited < 200) begin
      tick();
      waited++;
      if (!send_resp) check_val("moving", moving, 1'b1);
      if (frwrd != prev) begin
        check_val("frwrd", frwrd, prev - dec_step);
        prev = frwrd;
      end
    end
    if (!send_resp) report_stall("send_resp at the end of the move");
    check_val("frwrd", frwrd, 10'h000);
    check_val("moving", moving, 1'b0);
    repeat (4) tick();
    check_val("send_resp count", resp_cnt - resp_before, 1);
    check_val("fanfare_go count", fan_cnt - fan_before, is_fan);
    if (is_fan) check_val("frwrd at fanfare_go", fan_frwrd, full_spd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    rst_n = 1'b0;
    cmd = '0;
    cmd_rdy = 1'b0;
    cal_done = 1'b0;
    heading = '0;
    heading_rdy = 1'b0;
    ir = '0;
    seed = 52814;
    load_stimulus(load_ok);
    if (!load_ok) begin
      $display("No stimulus records could be read from %s", stim_file);
      $display("CHECKS FAILED");
      $finish;
    end else begin
      cycle_limit = recs.size() * 400 + 8 + 20;  // Worst case move per record.
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      #1;
      check_val("clr_cmd_rdy", clr_cmd_rdy, 1'b0);
      check_val("send_resp", send_resp, 1'b0);
      check_val("strt_cal", strt_cal, 1'b0);
      check_val("tour_go", tour_go, 1'b0);
      check_val("fanfare_go", fanfare_go, 1'b0);
      check_val("moving", moving, 1'b0);
      check_val("frwrd", frwrd, 10'h000);
      foreach (recs[i]) begin
        case (op_t'(recs[i].cmd_word[15:12]))
          TOUR:         run_tour(recs[i]);
          CAL:          run_cal(recs[i]);
          MOV, FANFARE: run_move(recs[i]);
          default: begin
            err_cnt++;
            $display("Stimulus record %0d holds an unknown opcode", i);
          end
        endcase
      end
      repeat (4) tick();
      $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* cmd_proc.f */
+incdir+include
hw/knight_cmd_pkg.sv
hw/heading_err.sv
hw/move_progress.sv
hw/cmd_sequencer.sv
hw/cmd_proc.sv
dv/cmd_proc_tb.sv

/* Bender.yml */
package:
  name: cmd_proc

export_include_dirs:
  - include

sources:
  - hw/knight_cmd_pkg.sv
  - hw/heading_err.sv
  - hw/move_progress.sv
  - hw/cmd_sequencer.sv
  - hw/cmd_proc.sv
  - target: simulation
    files:
      - dv/cmd_proc_tb.sv

/* dv/cmd_proc_stimulus.txt */
# cmd heading lft rght exp_error ramp_steps, all in hex
# ramp_steps is the heading_rdy count from standstill to full speed, 00 where unused
6000 000 0 0 000 00
2000 000 0 0 000 00
4402 000 0 0 BF1 18
4001 100 1 0 2FF 18
5C03 200 0 1 3F1 18
4801 7F0 1 1 1E0 18
2000 000 0 0 000 00
5102 F00 0 0 DF1 18
6000 000 0 0 000 00
